// File: Makefile
# Verilator build and run for the optical flow driver testbench

VERILATOR ?= verilator
TOP       ?= optflow_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/optflow_pkg.sv
// optical flow driver shared types
`default_nettype none

package optflow_pkg;

	// width of every microsecond count
	localparam int US_W = 16;

	// sensor register map, only what the driver touches
	typedef enum logic [6:0] {
		PRODUCT_ID         = 7'h00,
		CONFIGURATION_BITS = 7'h0a,
		MOTION_CLEAR       = 7'h12,
		OBSERVATION        = 7'h3d,
		MOTION_BURST       = 7'h50
	} adns_reg_e;

	typedef enum logic [2:0] {
		RESET_PULSE,
		CHECK_ID,
		CONFIGURE,
		IDLE,
		POLL_BURST,
		CLEAR_MOTION
	} seq_state_e;

	typedef struct packed {
		logic       write;   // bit 7 of command byte
		adns_reg_e  addr;
		logic [7:0] wdata;
		logic [2:0] nbytes;  // data bytes after command
		logic       to_fifo;
		logic       no_gap;  // back to back bytes
	} xfer_req_t;

	typedef struct packed {
		logic       en_spi;
		logic [7:0] sbuf;
	} spi_tx_t;

	typedef struct packed {
		logic       rx_rdy;
		logic [7:0] rbuf;
	} spi_rx_t;

	typedef struct packed {
		logic [7:0] data;
		logic [3:0] count;
		logic       full;
		logic       empty;
	} fifo_status_t;

	localparam logic [7:0] PRODUCT_ID_VALUE = 8'h17;
	localparam logic [7:0] RESOLUTION_1600  = 8'h10;  // 1600 cpi
	localparam logic [2:0] BURST_LEN        = 3'd7;
	localparam int         FIFO_DEPTH       = 8;
	localparam int         FIFO_PTR_W       = $clog2(FIFO_DEPTH);

	// delays in microseconds
	localparam logic [US_W-1:0] RESET_PULSE_US    = 16'd20;
	localparam logic [US_W-1:0] POWERUP_US        = 16'd500;
	localparam logic [US_W-1:0] WRITE_ADDR_GAP_US = 16'd5;
	localparam logic [US_W-1:0] READ_ADDR_GAP_US  = 16'd75;
	localparam logic [US_W-1:0] BYTE_GAP_US       = 16'd6;
	localparam logic [US_W-1:0] END_GAP_US        = 16'd40;

	localparam int DEFAULT_CLKS_PER_US = 24;
	localparam int DEFAULT_POLL_US     = 20000;

endpackage

`default_nettype wire

// File: files.f
common/optflow_pkg.sv
source/us_timer.sv
source/burst_fifo.sv
sensor_seq/transfer_engine.sv
sensor_seq/sensor_sequencer.sv
source/optflow_driver.sv
test/optflow_properties.sv
test/sensor_spi_model.sv
test/optflow_tb.sv

// File: sensor_seq/sensor_sequencer.sv
// sensor bring-up and poll sequencer
`timescale 1ns/1ns
`default_nettype none

module sensor_sequencer #(
	parameter int CLKS_PER_US = optflow_pkg::DEFAULT_CLKS_PER_US,
	parameter int POLL_US     = optflow_pkg::DEFAULT_POLL_US
) (
	input  wire                     CLK,
	input  wire                     RSTn,
	input  wire                     en,
	output logic                    sensor_rst,
	output optflow_pkg::xfer_req_t  req,
	output logic                    start,
	input  wire                     done,
	input  wire [7:0]               reg_value,
	output logic                    time_mark,
	output optflow_pkg::seq_state_e state
);
	import optflow_pkg::*;

	logic [1:0]      step;
	logic            issued;     // start already sent in this step
	logic            done_hit;   // done seen while frozen
	logic            tmr_hit;    // timeup seen while frozen
	logic            xfer_done;
	logic            tmr_done;
	logic            timeup;
	logic            rst_start;
	logic            pwr_start;
	logic            poll_entry;
	logic            tmr_start;
	logic [US_W-1:0] tmr_count;
	xfer_req_t       cur_req;

	function automatic xfer_req_t make_req(input logic write, input adns_reg_e addr,
		input logic [7:0] wdata, input logic [2:0] nbytes, input logic burst);
		xfer_req_t r;
		r.write   = write;
		r.addr    = addr;
		r.wdata   = wdata;
		r.nbytes  = nbytes;
		r.to_fifo = burst;
		r.no_gap  = burst;
		return r;
	endfunction

	assign xfer_done  = done | done_hit;
	assign tmr_done   = timeup | tmr_hit;
	assign rst_start  = en && (state == RESET_PULSE) && (step == 2'd0);
	assign pwr_start  = en && (state == RESET_PULSE) && (step == 2'd1) && tmr_done;
	assign poll_entry = en && issued && xfer_done &&
		(((state == CONFIGURE) && (step == 2'd1)) || (state == CLEAR_MOTION));
	assign tmr_start  = rst_start | pwr_start | poll_entry;
	assign tmr_count  = rst_start ? RESET_PULSE_US : (pwr_start ? POWERUP_US : US_W'(POLL_US));

	always_comb begin
		case (state)
			CONFIGURE:    cur_req = (step == 2'd0) ?
				make_req(1'b1, CONFIGURATION_BITS, RESOLUTION_1600, 3'd1, 1'b0) :
				make_req(1'b0, OBSERVATION, 8'h00, 3'd1, 1'b0);
			POLL_BURST:   cur_req = make_req(1'b0, MOTION_BURST, 8'h00, BURST_LEN, 1'b1);
			CLEAR_MOTION: cur_req = make_req(1'b1, MOTION_CLEAR, 8'h00, 3'd1, 1'b0);
			default:      cur_req = make_req(1'b0, PRODUCT_ID, 8'h00, 3'd1, 1'b0);
		endcase
	end

	us_timer #(.CLKS_PER_US(CLKS_PER_US)) i_us_timer (
		.CLK   (CLK),
		.RSTn  (RSTn),
		.start (tmr_start),
		.count (tmr_count),
		.timeup(timeup)
	);

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state      <= RESET_PULSE;
			step       <= '0;
			issued     <= 1'b0;
			done_hit   <= 1'b0;
			tmr_hit    <= 1'b0;
			sensor_rst <= 1'b0;
			start      <= 1'b0;
			req        <= '0;
			time_mark  <= 1'b0;
		end else begin
			start     <= 1'b0;
			time_mark <= 1'b0;
			if (tmr_start)
				tmr_hit <= 1'b0;
			else if (timeup)
				tmr_hit <= 1'b1;
			if (done)
				done_hit <= 1'b1;
			if (en) begin
				case (state)
					RESET_PULSE: begin
						case (step)
							2'd0: begin
								sensor_rst <= 1'b1;
								step       <= 2'd1;
							end
							2'd1: if (tmr_done) begin
								sensor_rst <= 1'b0;  // power-up wait follows
								step       <= 2'd2;
							end
							default: if (tmr_done) begin
								step  <= 2'd0;
								state <= CHECK_ID;
							end
						endcase
					end
					IDLE: if (tmr_done)
						state <= POLL_BURST;  // poll period over
					default: begin
						if (!issued) begin
							start    <= 1'b1;
							req      <= cur_req;
							issued   <= 1'b1;
							done_hit <= 1'b0;
						end else if (xfer_done) begin
							issued <= 1'b0;
							case (state)
								CHECK_ID: begin
									step  <= 2'd0;
									state <= (reg_value == PRODUCT_ID_VALUE) ? CONFIGURE : RESET_PULSE;
								end
								CONFIGURE: begin
									step <= 2'd0;
									if (step == 2'd0)
										step <= 2'd1;
									else
										state <= IDLE;
								end
								POLL_BURST: begin
									time_mark <= 1'b1;  // end of frame
									state     <= CLEAR_MOTION;
								end
								default: state <= IDLE;
							endcase
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sensor_seq/transfer_engine.sv
// sensor register transfer engine
`timescale 1ns/1ns
`default_nettype none

module transfer_engine #(
	parameter int CLKS_PER_US = optflow_pkg::DEFAULT_CLKS_PER_US
) (
	input  wire                        CLK,
	input  wire                        RSTn,
	input  wire optflow_pkg::xfer_req_t req,
	input  wire                        start,
	output logic                       done,
	output logic [7:0]                 reg_value,
	output logic                       csn,
	output optflow_pkg::spi_tx_t       spi_tx,
	input  wire optflow_pkg::spi_rx_t  spi_rx,
	output logic                       fifo_wr,
	output logic [7:0]                 fifo_data
);
	import optflow_pkg::*;

	typedef enum logic [2:0] {
		E_IDLE,
		E_CMD,
		E_ADDR_GAP,
		E_DATA,
		E_BYTE_GAP,
		E_END_GAP
	} eng_state_e;

	eng_state_e      state;
	xfer_req_t       req_q;
	logic [2:0]      byte_cnt;
	logic            last_byte;
	logic            rx_cmd;
	logic            rx_data;
	logic            issue_cmd;
	logic            issue_data;
	logic            en_spi_q;
	logic [7:0]      sbuf_q;
	logic            tmr_start;
	logic [US_W-1:0] tmr_count;
	logic            timeup;

	assign rx_cmd     = (state == E_CMD) && spi_rx.rx_rdy;
	assign rx_data    = (state == E_DATA) && spi_rx.rx_rdy;
	assign last_byte  = (byte_cnt == req_q.nbytes - 3'd1);
	assign issue_cmd  = (state == E_IDLE) && start;
	assign issue_data = (((state == E_ADDR_GAP) || (state == E_BYTE_GAP)) && timeup) ||
		(rx_data && !last_byte && req_q.no_gap);

	assign fifo_wr   = rx_data && req_q.to_fifo;  // data bytes only, never the echo
	assign fifo_data = spi_rx.rbuf;
	assign spi_tx    = '{en_spi: en_spi_q, sbuf: sbuf_q};

	always_comb begin
		tmr_start = 1'b0;
		tmr_count = END_GAP_US;
		if (rx_cmd) begin
			tmr_start = 1'b1;
			if (req_q.nbytes != 3'd0)
				tmr_count = req_q.write ? WRITE_ADDR_GAP_US : READ_ADDR_GAP_US;
		end else if (rx_data && (last_byte || !req_q.no_gap)) begin
			tmr_start = 1'b1;
			if (!last_byte)
				tmr_count = BYTE_GAP_US;
		end
	end

	us_timer #(.CLKS_PER_US(CLKS_PER_US)) i_us_timer (
		.CLK   (CLK),
		.RSTn  (RSTn),
		.start (tmr_start),
		.count (tmr_count),
		.timeup(timeup)
	);

	always_ff @(posedge CLK) begin
		if (issue_cmd) begin
			req_q  <= req;
			sbuf_q <= {req.write, req.addr};
		end else if (issue_data) begin
			sbuf_q <= req_q.write ? req_q.wdata : 8'h00;  // dummy byte on reads
		end
		if (rx_data && !req_q.to_fifo)
			reg_value <= spi_rx.rbuf;
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state    <= E_IDLE;
			byte_cnt <= '0;
			csn      <= 1'b1;
			en_spi_q <= 1'b0;
			done     <= 1'b0;
		end else begin
			en_spi_q <= issue_cmd | issue_data;
			done     <= 1'b0;
			case (state)
				E_IDLE: if (start) begin
					csn      <= 1'b0;
					byte_cnt <= '0;
					state    <= E_CMD;
				end
				E_CMD: if (spi_rx.rx_rdy) begin
					if (req_q.nbytes == 3'd0) begin
						csn   <= 1'b1;
						state <= E_END_GAP;
					end else begin
						state <= E_ADDR_GAP;
					end
				end
				E_ADDR_GAP, E_BYTE_GAP: if (timeup)
					state <= E_DATA;
				E_DATA: if (spi_rx.rx_rdy) begin
					byte_cnt <= byte_cnt + 3'd1;
					if (last_byte) begin
						csn   <= 1'b1;  // release right after last byte
						state <= E_END_GAP;
					end else if (!req_q.no_gap) begin
						state <= E_BYTE_GAP;
					end
				end
				E_END_GAP: if (timeup) begin
					done  <= 1'b1;
					state <= E_IDLE;
				end
				default: state <= E_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/burst_fifo.sv
// motion burst byte FIFO
`timescale 1ns/1ns
`default_nettype none

module burst_fifo (
	input  wire                       CLK,
	input  wire                       RSTn,
	input  wire                       wr,
	input  wire [7:0]                 data,
	input  wire                       rd,
	output optflow_pkg::fifo_status_t status
);
	import optflow_pkg::*;

	logic [7:0]            mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [3:0]            count;
	logic                  full;
	logic                  empty;
	logic                  do_wr;
	logic                  do_rd;

	assign full  = (count == 4'(FIFO_DEPTH));
	assign empty = (count == 4'd0);
	assign do_wr = wr && !full;   // dropped when full
	assign do_rd = rd && !empty;

	assign status = '{data: mem[rd_ptr], count: count, full: full, empty: empty};

	always_ff @(posedge CLK) begin
		if (do_wr)
			mem[wr_ptr] <= data;
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 4'd1;
			else if (do_rd && !do_wr)
				count <= count - 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: source/optflow_driver.sv
// optical flow sensor driver top
`timescale 1ns/1ns
`default_nettype none

module optflow_driver #(
	parameter int CLKS_PER_US = optflow_pkg::DEFAULT_CLKS_PER_US,
	parameter int POLL_US     = optflow_pkg::DEFAULT_POLL_US
) (
	input  wire                       CLK,
	input  wire                       RSTn,
	input  wire                       en,
	output logic                      csn,
	output logic                      sensor_rst,
	output optflow_pkg::spi_tx_t      spi_tx,
	input  wire optflow_pkg::spi_rx_t spi_rx,
	input  wire                       fifo_rd,
	output optflow_pkg::fifo_status_t fifo,
	output logic [7:0]                dat_out,
	output logic                      time_mark,
	output optflow_pkg::seq_state_e   sta_out
);
	import optflow_pkg::*;

	xfer_req_t  req;
	logic       start;
	logic       done;
	logic       fifo_wr;
	logic [7:0] fifo_data;

	sensor_sequencer #(
		.CLKS_PER_US(CLKS_PER_US),
		.POLL_US    (POLL_US)
	) i_sensor_sequencer (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.en        (en),
		.sensor_rst(sensor_rst),
		.req       (req),
		.start     (start),
		.done      (done),
		.reg_value (dat_out),
		.time_mark (time_mark),
		.state     (sta_out)
	);

	transfer_engine #(.CLKS_PER_US(CLKS_PER_US)) i_transfer_engine (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.req      (req),
		.start    (start),
		.done     (done),
		.reg_value(dat_out),
		.csn      (csn),
		.spi_tx   (spi_tx),
		.spi_rx   (spi_rx),
		.fifo_wr  (fifo_wr),
		.fifo_data(fifo_data)
	);

	burst_fifo i_burst_fifo (
		.CLK   (CLK),
		.RSTn  (RSTn),
		.wr    (fifo_wr),
		.data  (fifo_data),
		.rd    (fifo_rd),
		.status(fifo)
	);

endmodule

`default_nettype wire

// File: source/us_timer.sv
// microsecond countdown timer
`timescale 1ns/1ns
`default_nettype none

module us_timer #(
	parameter int CLKS_PER_US = optflow_pkg::DEFAULT_CLKS_PER_US
) (
	input  wire                         CLK,
	input  wire                         RSTn,
	input  wire                         start,
	input  wire [optflow_pkg::US_W-1:0] count,
	output logic                        timeup
);
	import optflow_pkg::*;

	logic [US_W-1:0] pre;     // clocks within current microsecond
	logic [US_W-1:0] remain;  // microseconds left
	logic            running;
	logic            tick;

	assign tick   = running && (pre == US_W'(CLKS_PER_US - 1));
	assign timeup = tick && (remain == US_W'(1));

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			pre     <= '0;
			remain  <= '0;
			running <= 1'b0;
		end else if (start) begin  // restart wins over expiry
			pre     <= '0;
			remain  <= count;
			running <= 1'b1;
		end else if (running) begin
			if (tick) begin
				pre    <= '0;
				remain <= remain - 1'b1;
				if (remain == US_W'(1))
					running <= 1'b0;
			end else begin
				pre <= pre + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/optflow_properties.sv
// driver protocol assertions
`timescale 1ns/1ns
`default_nettype none

module optflow_properties (
	input wire                            CLK,
	input wire                            RSTn,
	input wire                            csn,
	input wire                            sensor_rst,
	input wire optflow_pkg::spi_tx_t      spi_tx,
	input wire                            time_mark,
	input wire optflow_pkg::fifo_status_t fifo
);
	import optflow_pkg::*;

	int fail_count = 0;  // violations so far

	// no SPI traffic while the sensor sits in reset
	csn_idle_in_reset: assert property (@(posedge CLK) disable iff (!RSTn)
		sensor_rst |-> csn)
		else begin
			fail_count++;
			$error("csn low while sensor_rst is high");
		end

	en_spi_with_csn: assert property (@(posedge CLK) disable iff (!RSTn)
		$rose(spi_tx.en_spi) |-> !csn)
		else begin
			fail_count++;
			$error("en_spi rose with csn high");
		end

	time_mark_single: assert property (@(posedge CLK) disable iff (!RSTn)
		time_mark |=> !time_mark)
		else begin
			fail_count++;
			$error("time_mark longer than one cycle");
		end

	fifo_count_bound: assert property (@(posedge CLK) disable iff (!RSTn)
		fifo.count <= 4'(FIFO_DEPTH))
		else begin
			fail_count++;
			$error("FIFO count above depth");
		end

endmodule

bind optflow_driver optflow_properties i_optflow_properties (
	.CLK       (CLK),
	.RSTn      (RSTn),
	.csn       (csn),
	.sensor_rst(sensor_rst),
	.spi_tx    (spi_tx),
	.time_mark (time_mark),
	.fifo      (fifo)
);

`default_nettype wire

// File: test/optflow_tb.sv
// optical flow driver testbench
`timescale 1ns/1ns
`default_nettype none

module optflow_tb;
	import optflow_pkg::*;

	localparam int CLKS_PER_US = 2;
	localparam int POLL_US     = 300;
	localparam int NUM_FRAMES  = 8;
	localparam int READ_US     = int'(READ_ADDR_GAP_US) + int'(END_GAP_US) + 10;
	localparam int WRITE_US    = int'(WRITE_ADDR_GAP_US) + int'(END_GAP_US) + 10;
	localparam int BURST_US    = READ_US + 4 * int'(BURST_LEN);
	// two reset attempts, then configuration write and observation read
	localparam int BRINGUP_US  = 2 * (int'(RESET_PULSE_US) + int'(POWERUP_US) + READ_US) +
		WRITE_US + READ_US;
	localparam int TIMEOUT_CYCLES = 2 * (BRINGUP_US + NUM_FRAMES * (POLL_US + BURST_US)) *
		CLKS_PER_US;
	localparam bit [NUM_FRAMES-1:0] READ_MASK   = 8'b1100_0111;  // frames 3 to 5 fill FIFO
	localparam bit [NUM_FRAMES-1:0] EN_LOW_MASK = 8'b0000_0010;

	typedef struct packed {
		logic [55:0] bytes;      // byte k at bits 8k+7:8k
		logic        read_fifo;
		logic        en_low;     // hold en low in IDLE first
	} frame_t;

	logic         CLK;
	logic         RSTn;
	logic         en;
	logic         fifo_rd;
	logic         csn;
	logic         sensor_rst;
	logic         time_mark;
	spi_tx_t      spi_tx;
	spi_rx_t      spi_rx;
	fifo_status_t fifo;
	logic [7:0]   dat_out;
	seq_state_e   sta_out;
	logic [55:0]  burst_bytes;
	logic [7:0]   cfg_value;
	int           cfg_writes;
	int           clear_writes;
	frame_t       frames [NUM_FRAMES];
	logic [7:0]   exp_q [$];  // bytes the FIFO should hold
	int           cycles = 0;
	int           rst_pulses = 0;
	int           csn_falls = 0;
	int           marks = 0;
	logic         rst_d = 1'b0;
	logic         csn_d = 1'b1;

	optflow_driver #(.CLKS_PER_US(CLKS_PER_US), .POLL_US(POLL_US)) i_optflow_driver (
		.CLK(CLK), .RSTn(RSTn), .en(en), .csn(csn), .sensor_rst(sensor_rst),
		.spi_tx(spi_tx), .spi_rx(spi_rx), .fifo_rd(fifo_rd), .fifo(fifo),
		.dat_out(dat_out), .time_mark(time_mark), .sta_out(sta_out)
	);

	sensor_spi_model i_sensor_spi_model (
		.CLK(CLK), .csn(csn), .spi_tx(spi_tx), .spi_rx(spi_rx), .burst_bytes(burst_bytes),
		.cfg_value(cfg_value), .cfg_writes(cfg_writes), .clear_writes(clear_writes)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: DUT made no progress within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$fatal(1, "timeout");
		end
		if (i_optflow_driver.i_optflow_properties.fail_count != 0) begin
			$display("a protocol assertion on the DUT failed");
			$display("tests failed");
			$fatal(1, "assertion failure");
		end
		if (RSTn) begin
			rst_d <= sensor_rst;
			csn_d <= csn;
			if (sensor_rst && !rst_d)
				rst_pulses <= rst_pulses + 1;
			if (!csn && csn_d)
				csn_falls <= csn_falls + 1;
			if (time_mark)
				marks <= marks + 1;
		end
	end

	task automatic check(input int actual, input int expected, input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic build_table;
		int seed;
		seed = 2;
		for (int k = 0; k < NUM_FRAMES; k++) begin
			frames[k] = '0;
			for (int b = 0; b < int'(BURST_LEN); b++)
				frames[k].bytes = {frames[k].bytes[47:0], 8'($random(seed))};
			frames[k].read_fifo = READ_MASK[k];
			frames[k].en_low    = EN_LOW_MASK[k];
		end
	endtask

	task automatic hold_enable_low;
		int falls;
		while (sta_out != IDLE)
			@(negedge CLK);
		falls = csn_falls;
		en = 1'b0;
		repeat ((POLL_US + 50) * CLKS_PER_US) @(negedge CLK);  // past one poll period
		check(csn_falls, falls, "csn falls with en low");
		check(int'(sta_out), int'(IDLE), "state with en low");
		en = 1'b1;
	endtask

	task automatic drain_fifo;
		logic [7:0] exp;
		while (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			check(int'(fifo.empty), 0, "FIFO empty before read");
			check(int'(fifo.data), int'(exp), "FIFO head byte");
			fifo_rd = 1'b1;
			@(negedge CLK);
			fifo_rd = 1'b0;
		end
		check(int'(fifo.empty), 1, "FIFO empty after drain");
	endtask

	initial begin
		RSTn        = 1'b0;
		en          = 1'b0;
		fifo_rd     = 1'b0;
		burst_bytes = '0;
		build_table();
		repeat (4) @(negedge CLK);
		RSTn = 1'b1;
		@(negedge CLK);
		check(int'(csn), 1, "csn after reset");
		check(int'(fifo.empty), 1, "FIFO empty after reset");
		check(int'(sta_out), int'(RESET_PULSE), "state after reset");
		check(int'(sensor_rst), 0, "sensor_rst before enable");
		burst_bytes = frames[0].bytes;
		en = 1'b1;
		while (rst_pulses == 0)
			@(negedge CLK);
		while (cfg_writes == 0)
			@(negedge CLK);
		check(rst_pulses, 2, "reset pulses before configuration");  // first ID read is wrong
		check(int'(cfg_value), 8'h10, "configuration byte");
		while (sta_out != IDLE)
			@(negedge CLK);
		check(int'(dat_out), 8'h93, "observation value");
		for (int k = 0; k < NUM_FRAMES; k++) begin
			burst_bytes = frames[k].bytes;
			if (frames[k].en_low)
				hold_enable_low();
			while (clear_writes < k + 1)
				@(negedge CLK);
			while (sta_out != IDLE)  // clear write complete
				@(negedge CLK);
			check(marks, k + 1, "time marks");
			check(clear_writes, k + 1, "motion clear writes");
			for (int b = 0; b < int'(BURST_LEN); b++)
				if (exp_q.size() < FIFO_DEPTH)
					exp_q.push_back(8'(frames[k].bytes >> (8 * b)));
			check(int'(fifo.count), exp_q.size(), "FIFO count");
			check(int'(fifo.full), int'(exp_q.size() == FIFO_DEPTH), "FIFO full flag");
			if (frames[k].read_fifo)
				drain_fifo();
		end
		if (i_optflow_driver.i_optflow_properties.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("a protocol assertion on the DUT failed");
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/sensor_spi_model.sv
// sensor and SPI byte master model
`timescale 1ns/1ns
`default_nettype none

module sensor_spi_model (
	input  wire                       CLK,
	input  wire                       csn,
	input  wire optflow_pkg::spi_tx_t spi_tx,
	output optflow_pkg::spi_rx_t      spi_rx,
	input  wire [55:0]                burst_bytes,
	output logic [7:0]                cfg_value,
	output int                        cfg_writes,
	output int                        clear_writes
);
	import optflow_pkg::*;

	spi_rx_t    rx_q = '0;
	logic [7:0] cmd = 8'h00;      // command byte of current transaction
	logic [7:0] reply = 8'h00;
	logic [7:0] cfg_q = 8'h00;
	int         idx = 0;          // byte position after csn fall
	int         delay = 0;        // cycles left until rx_rdy
	int         id_reads = 0;
	int         cfg_count = 0;
	int         clear_count = 0;

	assign spi_rx       = rx_q;
	assign cfg_value    = cfg_q;
	assign cfg_writes   = cfg_count;
	assign clear_writes = clear_count;

	always @(negedge CLK) begin
		rx_q.rx_rdy <= 1'b0;
		if (csn)
			idx <= 0;
		if (delay > 0) begin
			delay <= delay - 1;
			if (delay == 1) begin
				rx_q.rx_rdy <= 1'b1;  // seen at the third rising edge
				rx_q.rbuf   <= reply;
			end
		end
		if (spi_tx.en_spi) begin
			delay <= 2;
			idx   <= idx + 1;
			reply <= 8'h00;
			if (idx == 0) begin
				cmd <= spi_tx.sbuf;
			end else if (cmd[7]) begin
				if (cmd[6:0] == CONFIGURATION_BITS) begin
					cfg_q     <= spi_tx.sbuf;
					cfg_count <= cfg_count + 1;
				end
				if (cmd[6:0] == MOTION_CLEAR)
					clear_count <= clear_count + 1;
			end else begin
				case (cmd[6:0])
					PRODUCT_ID: begin
						reply    <= (id_reads == 0) ? 8'h00 : 8'h17;  // bad ID first time
						id_reads <= id_reads + 1;
					end
					OBSERVATION:  reply <= 8'h93;
					MOTION_BURST: reply <= 8'(burst_bytes >> (8 * (idx - 1)));
					default:      reply <= 8'h00;
				endcase
			end
		end
	end

endmodule

`default_nettype wire
